/* Bender.yml */
package:
  name: vector_processor

sources:
  - include_dirs:
      - include
    files:
      - src/vec_pkg.sv
      - src/vec_decode.sv
      - src/vec_csr_regs.sv
      - src/vec_lsu.sv
      - src/vec_regfile.sv
      - src/vector_processor.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_vector_processor.sv

/* all.f */
+incdir+include
src/vec_pkg.sv
src/vec_decode.sv
src/vec_csr_regs.sv
src/vec_lsu.sv
src/vec_regfile.sv
src/vector_processor.sv
testbench/tb_vector_processor.sv

/* include/vec_macros.svh */
// Width, count and opcode constants for the vector datapath
// VLEN is fixed at 128 with LMUL 1, so VLMAX tops out at 16 elements
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Scalar and vector widths
`define VEC_XLEN        32          // Scalar word
`define VEC_VLEN        128         // One vector register
`define VEC_NUM_REGS    32          // v0 to v31

// Memory bus
`define VEC_DATA_BUS    32          // One element per beat
`define VEC_STRB_W      4           // Byte strobes per beat

// Element counts
`define VEC_MAX_ELEMS   16          // VLMAX at e8
`define VEC_VL_W        5           // Holds 0 to 16

// Major opcodes
`define VEC_OPC_OPV     7'b1010111
`define VEC_OPC_LOAD    7'b0000111
`define VEC_OPC_STORE   7'b0100111

// funct3 of vsetvli/vsetvl
`define VEC_F3_CFG      3'b111

`endif

/* src/vec_csr_regs.sv */
// vl and vtype registers with vsetvli/vsetvl execution
// LMUL 1 only; vta and vma are stored but tails are always left undisturbed
`timescale 1ns/100ps
`include "vec_macros.svh"

module vec_csr_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,   // Accepted strobe from the top
    input  vec_pkg::vec_op_e      op,
    input  vec_pkg::vec_inst_u    instruction,
    input  logic [`VEC_XLEN-1:0]  rs1_data,     // AVL
    input  logic [`VEC_XLEN-1:0]  rs2_data,     // vtype for vsetvl
    input  logic                  avl_is_max,
    output logic [`VEC_VL_W-1:0]  vl,
    output vec_pkg::vec_sew_e     sew,
    output logic [`VEC_XLEN-1:0]  csr_out,
    output logic                  csr_done
);

    localparam int XLEN = `VEC_XLEN;
    localparam int VL_W = `VEC_VL_W;

    logic [XLEN-1:0] vtype_q;       // vill in the top bit
    logic [XLEN-1:0] vtype_new;
    logic            vtype_ok;
    logic [VL_W-1:0] vlmax_new;
    logic [XLEN-1:0] avl;
    logic            cfg_go;

    // VLEN / SEW
    function automatic logic [VL_W-1:0] vlmax_of(input vec_pkg::vec_sew_e s);
        case (s)
            vec_pkg::sew_e8:  vlmax_of = VL_W'(`VEC_MAX_ELEMS);
            vec_pkg::sew_e16: vlmax_of = VL_W'(`VEC_MAX_ELEMS / 2);
            default:          vlmax_of = VL_W'(`VEC_MAX_ELEMS / 4);
        endcase
    endfunction

    assign cfg_go    = inst_valid && (op == vec_pkg::op_config);
    assign vtype_new = instruction.cfg.is_vsetvl ? rs2_data : XLEN'(instruction.cfg.zimm);

    // vlmul 000, vsew up to e32, reserved bits and vill clear
    assign vtype_ok  = (vtype_new[2:0] == 3'b000) && (vtype_new[5:3] <= 3'b010)
                    && (vtype_new[XLEN-1:8] == '0);
    assign vlmax_new = vlmax_of(vec_pkg::vec_sew_e'(vtype_new[4:3]));
    assign avl       = avl_is_max ? XLEN'(vlmax_new) : rs1_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vl       <= '0;
            vtype_q  <= {1'b1, {(XLEN-1){1'b0}}};   // Starts with vill set
            csr_done <= 1'b0;
        end else begin
            csr_done <= cfg_go;
            if (cfg_go && vtype_ok) begin
                vtype_q <= vtype_new;
                vl      <= (avl < XLEN'(vlmax_new)) ? avl[VL_W-1:0] : vlmax_new;  // min(AVL, VLMAX)
            end else if (cfg_go) begin
                vtype_q <= {1'b1, {(XLEN-1){1'b0}}};
                vl      <= '0;
            end
        end
    end

    assign sew     = vec_pkg::vec_sew_e'(vtype_q[4:3]);
    assign csr_out = XLEN'(vl);     // New vl back to the scalar side

    // vl stays inside VLMAX and is zero whenever vill is set
    a_vl_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        vl <= vlmax_of(sew));
    a_vill_zero_vl: assert property (@(posedge clk) disable iff (!rst_n)
        vtype_q[XLEN-1] |-> (vl == '0));

endmodule

/* src/vec_decode.sv */
// Combinational decode of the word held by the scalar side
// Only vsetvli/vsetvl and unit-stride unmasked loads and stores are legal
`timescale 1ns/100ps
`include "vec_macros.svh"

module vec_decode (
    input  vec_pkg::vec_inst_u instruction,     // Held until inst_done
    input  vec_pkg::vec_sew_e  sew,             // Current SEW from vtype
    output vec_pkg::vec_op_e   op,
    output logic [4:0]         vd_addr,
    output logic               avl_is_max,
    output vec_pkg::vec_sew_e  elem_sew,        // EEW from the width field
    output logic               is_vec
);

    logic width_ok;     // Width field names a supported EEW
    logic cfg_ok;
    logic mem_ok;

    // Memory width code to element width
    always_comb begin
        width_ok = 1'b1;
        case (instruction.mem.width)
            3'b000:  elem_sew = vec_pkg::sew_e8;
            3'b101:  elem_sew = vec_pkg::sew_e16;
            3'b110:  elem_sew = vec_pkg::sew_e32;
            default: begin
                elem_sew = vec_pkg::sew_e8;
                width_ok = 1'b0;                // e64 and scalar FP widths
            end
        endcase
    end

    // vsetivli has bit 30 set and lands here as illegal
    assign cfg_ok = (instruction.cfg.funct3 == `VEC_F3_CFG)
                 && (!instruction.cfg.is_vsetvl || (instruction.cfg.zimm[10:5] == 6'd0));

    assign mem_ok = width_ok
                 && (elem_sew == sew)                   // EEW must equal SEW
                 && (instruction.mem.nf == 3'b000)      // No segments
                 && !instruction.mem.mew
                 && (instruction.mem.mop == 2'b00)      // Unit-stride
                 && instruction.mem.vm                  // Unmasked
                 && (instruction.mem.lumop == 5'b00000);

    // Opcode picks which view is meaningful
    always_comb begin
        case (instruction.cfg.opcode)
            `VEC_OPC_OPV:   op = cfg_ok ? vec_pkg::op_config : vec_pkg::op_illegal;
            `VEC_OPC_LOAD:  op = mem_ok ? vec_pkg::op_load   : vec_pkg::op_illegal;
            `VEC_OPC_STORE: op = mem_ok ? vec_pkg::op_store  : vec_pkg::op_illegal;
            default:        op = vec_pkg::op_none;      // Not a vector opcode
        endcase
    end

    assign vd_addr    = instruction.mem.vd;             // Same bits as rd
    assign avl_is_max = (instruction.cfg.rs1 == 5'd0);  // x0 requests VLMAX

    assign is_vec = (op == vec_pkg::op_config)
                 || (op == vec_pkg::op_load)
                 || (op == vec_pkg::op_store);

endmodule

/* src/vec_lsu.sv */
// Unit-stride load/store sequencer with one element per memory beat
// Addresses assumed element-aligned; load data returns exactly one cycle after ld_req
`timescale 1ns/100ps
`include "vec_macros.svh"

module vec_lsu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,     // Raw strobe from the scalar side
    input  vec_pkg::vec_op_e          op,
    input  logic [4:0]                vd_addr,
    input  vec_pkg::vec_sew_e         elem_sew,
    input  logic [`VEC_VL_W-1:0]      vl,
    input  logic [`VEC_XLEN-1:0]      rs1_data,       // Base address
    input  logic [`VEC_VLEN-1:0]      rd_data,
    input  logic [`VEC_DATA_BUS-1:0]  mem2lsu_data,
    output logic [4:0]                rd_addr,
    output logic [4:0]                wr_addr,
    output logic                      wr_en,
    output logic [`VEC_VLEN-1:0]      wr_data,
    output logic [`VEC_XLEN-1:0]      lsu2mem_addr,
    output logic [`VEC_DATA_BUS-1:0]  lsu2mem_data,
    output logic [`VEC_STRB_W-1:0]    wr_strobe,
    output logic                      ld_req,
    output logic                      st_req,
    output logic                      busy,
    output logic                      lsu_done
);

    localparam int VLEN = `VEC_VLEN;
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_REQ   = 2'd1;     // One request per cycle
    localparam logic [1:0] S_DRAIN = 2'd2;     // Last load beat and writeback

    logic [1:0]                state_q;
    logic [`VEC_VL_W-1:0]      cnt_q;          // Index of the element requested now
    logic [`VEC_VL_W-1:0]      last_q;         // vl - 1
    logic                      is_load_q;
    logic [4:0]                vd_q;
    vec_pkg::vec_sew_e         sew_q;
    logic [`VEC_XLEN-1:0]      addr_q;
    logic [VLEN-1:0]           buf_q;          // Old vd with loaded elements merged in
    logic                      rsp_valid_q;    // Load data on the bus this cycle
    logic [`VEC_VL_W-1:0]      rsp_idx_q;
    logic [1:0]                rsp_lane_q;
    logic                      start;
    logic [2:0]                elem_bytes;
    logic [`VEC_STRB_W-1:0]    elem_strb;
    logic [`VEC_DATA_BUS-1:0]  elem_mask;
    logic [6:0]                st_off;         // Bit offset of the store element
    logic [6:0]                rsp_off;        // Bit offset of the returning element
    logic [`VEC_DATA_BUS-1:0]  st_elem;
    logic [`VEC_DATA_BUS-1:0]  ld_elem;
    logic [VLEN-1:0]           buf_next;

    assign start = inst_valid && (state_q == S_IDLE) && (vl != '0)
                && ((op == vec_pkg::op_load) || (op == vec_pkg::op_store));

    //////////////////////////////////////////////////
    // Element geometry
    assign elem_bytes = 3'd1 << sew_q;
    assign elem_strb  = (4'b0001 << elem_bytes) - 4'd1;     // 0001, 0011 or 1111
    assign elem_mask  = {{8{elem_strb[3]}}, {8{elem_strb[2]}},
                         {8{elem_strb[1]}}, {8{elem_strb[0]}}};
    assign st_off     = 7'({cnt_q, 3'b000} << sew_q);
    assign rsp_off    = 7'({rsp_idx_q, 3'b000} << sew_q);

    //////////////////////////////////////////////////
    // Store path, element into its byte lane
    assign st_elem      = `VEC_DATA_BUS'(rd_data >> st_off) & elem_mask;
    assign lsu2mem_data = st_elem << {addr_q[1:0], 3'b000};
    assign wr_strobe    = st_req ? (elem_strb << addr_q[1:0]) : '0;

    // Load path, lane down to bit 0 then up to the element slot
    assign ld_elem  = (mem2lsu_data >> {rsp_lane_q, 3'b000}) & elem_mask;
    assign buf_next = rsp_valid_q
                    ? ((buf_q & ~(VLEN'(elem_mask) << rsp_off)) | (VLEN'(ld_elem) << rsp_off))
                    : buf_q;

    // FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= S_IDLE;
            cnt_q       <= '0;
            rsp_valid_q <= 1'b0;
            lsu_done    <= 1'b0;
        end else begin
            rsp_valid_q <= ld_req;
            lsu_done    <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    cnt_q <= '0;
                    if (start) state_q <= S_REQ;
                end
                S_REQ: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == last_q) begin
                        state_q  <= is_load_q ? S_DRAIN : S_IDLE;
                        lsu_done <= !is_load_q;   // Store ends with its last request
                    end
                end
                S_DRAIN: begin
                    state_q  <= S_IDLE;
                    lsu_done <= 1'b1;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        rsp_idx_q  <= cnt_q;
        rsp_lane_q <= addr_q[1:0];
        buf_q      <= buf_next;
        if (start) begin
            is_load_q <= (op == vec_pkg::op_load);
            vd_q      <= vd_addr;
            sew_q     <= elem_sew;
            last_q    <= vl - 1'b1;
            addr_q    <= rs1_data;
            buf_q     <= rd_data;                   // Tail comes from here
        end else if (state_q == S_REQ) begin
            addr_q <= addr_q + elem_bytes;
        end
    end

    assign busy         = (state_q != S_IDLE);
    assign ld_req       = (state_q == S_REQ) && is_load_q;
    assign st_req       = (state_q == S_REQ) && !is_load_q;
    assign lsu2mem_addr = addr_q;
    assign rd_addr      = busy ? vd_q : vd_addr;    // vd read in the accept cycle too
    assign wr_en        = (state_q == S_DRAIN);
    assign wr_addr      = vd_q;
    assign wr_data      = buf_next;                 // Includes the final beat

    a_one_req: assert property (@(posedge clk) disable iff (!rst_n) !(ld_req && st_req));
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !inst_valid);

endmodule

/* src/vec_pkg.sv */
// Instruction views and enums shared across the vector datapath
// Field layout follows the RVV 1.0 encoding
package vec_pkg;

    //////////////////////////////////////////////////
    // Instruction word views

    // vsetvli / vsetvl view
    typedef struct packed {
        logic        is_vsetvl;     // Set for vsetvl
        logic [10:0] zimm;          // vtype immediate or rs2 for vsetvl
        logic [4:0]  rs1;           // AVL source, x0 means VLMAX
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } vec_cfg_fmt_t;

    // Load / store view
    typedef struct packed {
        logic [2:0]  nf;            // Segment fields minus one
        logic        mew;
        logic [1:0]  mop;           // Addressing mode
        logic        vm;            // High when unmasked
        logic [4:0]  lumop;         // lumop or sumop
        logic [4:0]  rs1;           // Base address register
        logic [2:0]  width;         // Element width code
        logic [4:0]  vd;            // vd for loads and vs3 for stores
        logic [6:0]  opcode;
    } vec_mem_fmt_t;

    // Same 32 bits read either way
    typedef union packed {
        vec_cfg_fmt_t cfg;
        vec_mem_fmt_t mem;
    } vec_inst_u;

    //////////////////////////////////////////////////
    // Enums

    typedef enum logic [2:0] {
        op_none,
        op_config,
        op_load,
        op_store,
        op_illegal
    } vec_op_e;

    // Matches the low bits of vtype.vsew
    typedef enum logic [1:0] {
        sew_e8  = 2'd0,
        sew_e16 = 2'd1,
        sew_e32 = 2'd2
    } vec_sew_e;

endpackage

/* src/vec_regfile.sv */
// 32 x 128-bit vector registers
// One asynchronous read port and one clocked write port
`timescale 1ns/100ps
`include "vec_macros.svh"

module vec_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [4:0]            rd_addr,
    output logic [`VEC_VLEN-1:0]  rd_data,
    input  logic                  wr_en,
    input  logic [4:0]            wr_addr,
    input  logic [`VEC_VLEN-1:0]  wr_data     // Full register, already merged
);

    logic [`VEC_VLEN-1:0] regs [`VEC_NUM_REGS];

    // Every register cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `VEC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // New data is visible the cycle after the write
    assign rd_data = regs[rd_addr];

endmodule

/* src/vector_processor.sv */
// Vector coprocessor datapath top
// One instruction in flight; the scalar side holds its inputs until inst_done
`timescale 1ns/100ps
`include "vec_macros.svh"

module vector_processor (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [`VEC_XLEN-1:0]      instruction,
    input  logic [`VEC_XLEN-1:0]      rs1_data,
    input  logic [`VEC_XLEN-1:0]      rs2_data,
    input  logic [`VEC_DATA_BUS-1:0]  mem2lsu_data,
    output logic [`VEC_XLEN-1:0]      lsu2mem_addr,
    output logic [`VEC_DATA_BUS-1:0]  lsu2mem_data,
    output logic [`VEC_STRB_W-1:0]    wr_strobe,
    output logic                      ld_req,
    output logic                      st_req,
    output logic                      is_vec,
    output logic                      inst_done,
    output logic [`VEC_XLEN-1:0]      csr_out
);

    vec_pkg::vec_inst_u   inst_u;       // Both views of the word
    vec_pkg::vec_op_e     op;
    vec_pkg::vec_sew_e    sew;
    vec_pkg::vec_sew_e    elem_sew;
    logic [4:0]           vd_addr;
    logic                 avl_is_max;
    logic [`VEC_VL_W-1:0] vl;
    logic                 csr_done;
    logic                 lsu_done;
    logic                 busy;
    logic [4:0]           rd_addr;
    logic [4:0]           wr_addr;
    logic [`VEC_VLEN-1:0] rd_data;
    logic [`VEC_VLEN-1:0] wr_data;
    logic                 wr_en;
    logic                 accept;       // inst_valid outside an LSU run
    logic                 quick_done;   // Illegal, none or zero-vl access

    assign inst_u = instruction;
    assign accept = inst_valid && !busy;

    //////////////////////////////////////////////////
    // Decode, CSRs, LSU and register file
    vec_decode   u_decode (.instruction (inst_u), .*);
    vec_csr_regs u_csr    (.instruction (inst_u), .inst_valid (accept), .*);
    vec_lsu      u_lsu    (.*);
    vec_regfile  u_regs   (.*);

    // Completes one cycle later with no datapath activity
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            quick_done <= 1'b0;
        end else begin
            quick_done <= accept && (!is_vec || ((op != vec_pkg::op_config) && (vl == '0)));
        end
    end

    assign inst_done = quick_done | csr_done | lsu_done;

endmodule

/* testbench/tb_vector_processor.sv */
// Directed testbench for the vector datapath with a 1 KB memory model
// Load data returns one cycle after ld_req and stores land in a separate byte array
`timescale 1ns/100ps
`include "vec_macros.svh"

module tb_vector_processor;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] instruction, rs1_data, rs2_data, mem2lsu_data;
    logic [31:0] lsu2mem_addr, lsu2mem_data, csr_out;
    logic [3:0]  wr_strobe;
    logic        ld_req, st_req, is_vec, inst_done;

    logic [31:0] mem [256];         // Source memory, random words
    logic [7:0]  st_mem [1024];     // Store target, byte wide
    integer      seed = 23;
    int          errors, tests_run, n_ld, n_st;
    int          elem_bytes;        // Element size of the current vtype
    int          req_base;          // rs1 of the instruction in flight

    vector_processor vector_processor_i (.*);

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Memory model
    always @(posedge clk) begin
        logic [31:0] rdata;
        logic        ld_hit;
        logic [3:0]  strb_exp;
        int          addr_exp;
        addr_exp = req_base + (n_ld + n_st) * elem_bytes;   // Unit stride from the base
        rdata    = mem[lsu2mem_addr[9:2]];
        ld_hit   = ld_req;
        if (ld_req || st_req)
            check_value("lsu2mem_addr", lsu2mem_addr, addr_exp);
        if (ld_req)
            n_ld++;
        if (st_req) begin
            n_st++;
            strb_exp = '0;
            for (int b = 0; b < elem_bytes; b++) begin
                strb_exp[(addr_exp + b) % 4] = 1'b1;        // Only the element bytes
            end
            check_value("wr_strobe", wr_strobe, strb_exp);
            for (int b = 0; b < 4; b++) begin
                if (wr_strobe[b])
                    st_mem[{lsu2mem_addr[9:2], 2'(b)}] = lsu2mem_data[8*b +: 8];
            end
        end
        #2 mem2lsu_data = ld_hit ? rdata : '0;      // Valid for the whole next cycle
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        $display("Test %-16s finished with %0d errors", name, errors - start);
    endtask

    function automatic logic [31:0] cfg_word(input logic vsetvl, input logic [10:0] zimm,
                                             input logic [4:0] rs1f);
        return {vsetvl, zimm, rs1f, `VEC_F3_CFG, 5'd1, `VEC_OPC_OPV};   // rd is x1
    endfunction

    // nf, mew and lumop zero, base in x10
    function automatic logic [31:0] mem_word(input logic [6:0] opc, input logic [1:0] mop,
                                             input logic vm, input logic [2:0] width,
                                             input logic [4:0] vd);
        return {3'b000, 1'b0, mop, vm, 5'd0, 5'd10, width, vd, opc};
    endfunction

    function automatic logic [2:0] width_code(input int bytes);
        case (bytes)
            1:       return 3'b000;
            2:       return 3'b101;
            default: return 3'b110;
        endcase
    endfunction

    // Little-endian element from the source memory
    function automatic logic [31:0] src_elem(input int addr);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < elem_bytes; b++) begin
            val[8*b +: 8] = mem[(addr + b) >> 2][8 * ((addr + b) % 4) +: 8];
        end
        return val;
    endfunction

    function automatic logic [31:0] dst_elem(input int addr);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < elem_bytes; b++) begin
            val[8*b +: 8] = st_mem[addr + b];
        end
        return val;
    endfunction

    // One instruction, held until inst_done; cycles counts from the inst_valid cycle
    task automatic issue(input logic [31:0] inst, input logic [31:0] rs1, input logic [31:0] rs2,
                         output int cycles, output logic vec_seen);
        inst_valid  = 1'b1;
        instruction = inst;
        rs1_data    = rs1;
        rs2_data    = rs2;
        req_base    = rs1;
        n_ld        = 0;
        n_st        = 0;
        #5 vec_seen = is_vec;       // Mid-cycle, decode settled
        @(posedge clk);
        #2 inst_valid = 1'b0;
        cycles = 1;
        while (!inst_done && cycles < 40) begin
            @(posedge clk);
            #2 cycles++;
        end
        if (!inst_done) begin
            $display("Timeout: no inst_done within 40 cycles for instruction %h", inst);
            errors++;
        end
        @(posedge clk);             // Let the done pulse drop
        #2;
    endtask

    // vsetvli at the given element size, returns the new vl
    task automatic set_vl(input int bytes, input int avl, output int vl);
        int   cycles;
        logic v;
        issue(cfg_word(1'b0, 11'($clog2(bytes)) << 3, 5'd1), avl, 0, cycles, v);
        check_value("config inst_done cycle", cycles, 1);
        vl         = csr_out;
        elem_bytes = bytes;
    endtask

    task automatic run_mem(input logic store, input int vd, input int base, input int vl);
        int         cycles;
        logic       v;
        logic [6:0] opc;
        opc = store ? `VEC_OPC_STORE : `VEC_OPC_LOAD;
        issue(mem_word(opc, 2'b00, 1'b1, width_code(elem_bytes), 5'(vd)), base, 0, cycles, v);
        check_value(store ? "st_req count" : "ld_req count", store ? n_st : n_ld, vl);
        check_value("other request count", store ? n_ld : n_st, 0);
        check_value("mem inst_done cycle", cycles, (vl == 0) ? 1 : vl + (store ? 1 : 2));
        check_value("is_vec", v, 1);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    task automatic config_cases();
        int   start, cycles, vl_exp, vlmax;
        logic v;
        int   avls [5];
        start = errors;
        avls  = '{0, 1, 3, 5, 20};
        for (int s = 0; s < 3; s++) begin
            vlmax = 128 / (8 << s);
            foreach (avls[k]) begin
                vl_exp = (avls[k] < vlmax) ? avls[k] : vlmax;
                issue(cfg_word(1'b0, 11'(s << 3), 5'd1), avls[k], 0, cycles, v);
                check_value("csr_out vsetvli", csr_out, vl_exp);
                check_value("config inst_done cycle", cycles, 1);
                issue(cfg_word(1'b1, 11'd2, 5'd1), avls[k], s << 3, cycles, v);  // vtype in x2
                check_value("csr_out vsetvl", csr_out, vl_exp);
            end
            issue(cfg_word(1'b0, 11'(s << 3), 5'd0), 3, 0, cycles, v);   // x0 asks for VLMAX
            check_value("csr_out avl max", csr_out, vlmax);
        end
        issue(cfg_word(1'b0, 11'h001, 5'd1), 4, 0, cycles, v);           // vlmul 001
        check_value("csr_out vsetvli lmul2", csr_out, 0);
        issue(cfg_word(1'b1, 11'd2, 5'd1), 4, 32'h1, cycles, v);
        check_value("csr_out vsetvl lmul2", csr_out, 0);
        report_test("config", start);
    endtask

    task automatic round_trip();
        int start, vl, src, dst;
        start = errors;
        for (int s = 0; s < 3; s++) begin
            set_vl(1 << s, 31, vl);
            check_value("vl", vl, 128 / (8 << s));
            src = ($random(seed) & 32'h7) * 64;     // Random 64-byte region, lower half
            dst = 512 + s * 64;
            run_mem(1'b0, 3, src, vl);
            run_mem(1'b1, 3, dst, vl);
            for (int i = 0; i < vl; i++) begin
                check_value("stored element", dst_elem(dst + i * elem_bytes),
                            src_elem(src + i * elem_bytes));
            end
        end
        report_test("round trip", start);
    endtask

    task automatic tail_undisturbed();
        int start, vl;
        start = errors;
        set_vl(1, 16, vl);
        run_mem(1'b0, 5, 64, vl);       // Region A in every element
        set_vl(1, 5, vl);
        run_mem(1'b0, 5, 192, vl);      // Region B over the first five
        set_vl(1, 16, vl);
        run_mem(1'b1, 5, 768, vl);
        for (int i = 0; i < 16; i++) begin
            check_value("tail element", dst_elem(768 + i), src_elem((i < 5) ? 192 + i : 64 + i));
        end
        report_test("tail undisturbed", start);
    endtask

    task automatic illegal_words();
        int          start, vl, cycles;
        logic        v;
        logic [31:0] words [4];
        start = errors;
        set_vl(4, 4, vl);
        words[0] = mem_word(`VEC_OPC_LOAD, 2'b00, 1'b0, 3'b110, 5'd4);  // Masked
        words[1] = mem_word(`VEC_OPC_LOAD, 2'b10, 1'b1, 3'b110, 5'd4);  // Strided
        words[2] = mem_word(`VEC_OPC_LOAD, 2'b00, 1'b1, 3'b000, 5'd4);  // e8 against SEW 32
        words[3] = 32'h0015_0513;                                        // addi a0, a0, 1
        foreach (words[k]) begin
            issue(words[k], 256, 0, cycles, v);
            check_value("is_vec", v, 0);
            check_value("request count", n_ld + n_st, 0);
            check_value("illegal inst_done cycle", cycles, 1);
        end
        report_test("illegal", start);
    endtask

    task automatic zero_length();
        int start, vl;
        start = errors;
        set_vl(1, 16, vl);
        run_mem(1'b0, 7, 320, vl);
        set_vl(1, 0, vl);
        check_value("vl", vl, 0);
        run_mem(1'b0, 7, 448, 0);       // Must leave v7 alone
        run_mem(1'b1, 7, 896, 0);
        set_vl(1, 16, vl);
        run_mem(1'b1, 7, 960, vl);
        for (int i = 0; i < 16; i++) begin
            check_value("element after vl 0", dst_elem(960 + i), src_elem(320 + i));
        end
        report_test("zero length", start);
    endtask

    initial begin
        inst_valid   = 1'b0;
        instruction  = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        mem2lsu_data = '0;
        rst_n        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        n_ld         = 0;
        n_st         = 0;
        elem_bytes   = 1;
        req_base     = 0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = $random(seed);
        end
        for (int a = 0; a < 1024; a++) begin
            st_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'ha5;     // Marks untouched bytes
        end
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        config_cases();
        round_trip();
        tail_undisturbed();
        illegal_words();
        zero_length();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
